//--- tb.f
rtl/ppu_pkg.sv
rtl/ppu_ifs.sv
rtl/frame_timing.sv
rtl/ppu_regs.sv
rtl/bg_renderer.sv
rtl/mem_arbiter.sv
rtl/video_mem.sv
rtl/ppu.sv
sim/tb_clk_gen.sv
sim/tb_ppu.sv

//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_ppu
FILELIST   = tb.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_ppu.sv
`timescale 1ns/1ps

module tb_ppu;

    localparam int clk_period   = 8;
    localparam int dots         = int'(ppu_pkg::dots_per_line);
    localparam int lines        = int'(ppu_pkg::lines_per_frame);
    localparam int vis_width    = int'(ppu_pkg::visible_width);
    localparam int vis_lines    = int'(ppu_pkg::visible_lines);
    localparam int frame_cycles = dots * lines;
    // flag changes one edge after dot 1 of its line
    localparam int set_edge     = int'(ppu_pkg::vblank_line) * dots + 2;
    localparam int clear_edge   = int'(ppu_pkg::prerender_line) * dots + 2;
    localparam int frames_run   = 5;

    logic              clk;
    logic              rst_n;
    ppu_pkg::reg_sel_t reg_sel;
    logic              reg_we;
    logic              reg_re;
    logic [7:0]        reg_wdata;
    logic [7:0]        reg_rdata;
    logic              nmi_n;
    logic              pixel_valid;
    logic [7:0]        pixel_x;
    logic [7:0]        pixel_y;
    logic [5:0]        pixel_color;

    logic [7:0]  shadow_nt [ppu_pkg::nt_size];
    logic [5:0]  shadow_pal [ppu_pkg::pal_size];
    logic [7:0]  ctrl_model;
    logic [7:0]  mask_model;
    logic [13:0] vaddr_model;
    logic [7:0]  buf_model;
    logic        buf_known;
    int          edge_cnt = 0;
    int          pixel_cnt = 0;
    int          pixel_errs = 0;
    int          value_errs = 0;
    int          other_errs = 0;

    tb_clk_gen #(.period_ns(clk_period), .reset_cycles(3)) i_clk_gen (.clk, .rst_n);

    ppu i_ppu (
        .clk, .rst_n, .reg_sel, .reg_we, .reg_re, .reg_wdata, .reg_rdata, .nmi_n,
        .pixel_valid, .pixel_x, .pixel_y, .pixel_color
    );

    initial begin
        reg_sel   = ppu_pkg::reg_ctrl;
        reg_we    = 1'b0;
        reg_re    = 1'b0;
        reg_wdata = 8'h00;
    end

    // expected colour of dot (x, y) from the shadow memories
    function automatic logic [5:0] ref_color(logic [7:0] x, logic [7:0] y, logic [7:0] m);
        logic [3:0] idx;
        logic [4:0] pidx;
        logic [5:0] color;
        idx  = shadow_nt[{y[7:3], x[7:3]}][3:0];
        pidx = {1'b0, idx};
        if (idx[1:0] == 2'b00) begin
            pidx = '0;
        end
        if (x < 8'd8 && !m[1]) begin
            pidx = '0;
        end
        color = shadow_pal[pidx];
        if (m[0]) begin
            color = color & ppu_pkg::greyscale_mask;
        end
        return color;
    endfunction

    // what a cpu read of video address a should see
    function automatic logic [7:0] mem_value(logic [13:0] a);
        if (a >= 14'h2000 && a <= 14'h23FF) begin
            return shadow_nt[a[9:0]];
        end else if (a >= 14'h3F00 && a <= 14'h3F1F) begin
            return {2'b00, shadow_pal[a[4:0]]};
        end
        return 8'h00;
    endfunction

    task automatic write_reg(input ppu_pkg::reg_sel_t sel, input logic [7:0] data);
        @(posedge clk);
        reg_sel   <= sel;
        reg_we    <= 1'b1;
        reg_wdata <= data;
        @(posedge clk);
        reg_we <= 1'b0;
        if (sel == ppu_pkg::reg_ctrl) begin
            ctrl_model = data;
        end
        if (sel == ppu_pkg::reg_mask) begin
            mask_model = data;
        end
    endtask

    task automatic read_reg(input ppu_pkg::reg_sel_t sel, output logic [7:0] data);
        @(posedge clk);
        reg_sel <= sel;
        reg_re  <= 1'b1;
        @(posedge clk);
        reg_re <= 1'b0;
        @(negedge clk);
        data = reg_rdata;
    endtask

    task automatic set_vaddr(input logic [13:0] a);
        write_reg(ppu_pkg::reg_addr, {2'b00, a[13:8]});
        write_reg(ppu_pkg::reg_addr, a[7:0]);
        vaddr_model = a;
    endtask

    task automatic vram_write(input logic [7:0] data);
        write_reg(ppu_pkg::reg_data, data);
        if (vaddr_model >= 14'h2000 && vaddr_model <= 14'h23FF) begin
            shadow_nt[vaddr_model[9:0]] = data;
        end else if (vaddr_model >= 14'h3F00 && vaddr_model <= 14'h3F1F) begin
            shadow_pal[vaddr_model[4:0]] = data[5:0];
        end
        vaddr_model = vaddr_model + (ctrl_model[2] ? 14'd32 : 14'd1);
    endtask

    // a data read returns the buffer, then the buffer takes the addressed byte
    task automatic vram_read_check();
        logic [7:0] got;
        read_reg(ppu_pkg::reg_data, got);
        if (buf_known) begin
            assert (got == buf_model) else begin
                value_errs++;
                $display("[ERROR] %0t reg_rdata at vaddr %04h got %02h expected %02h",
                         $time, vaddr_model, got, buf_model);
            end
        end
        buf_model   = mem_value(vaddr_model);
        buf_known   = 1'b1;
        vaddr_model = vaddr_model + (ctrl_model[2] ? 14'd32 : 14'd1);
    endtask

    task automatic random_palette_writes(input int count);
        logic [31:0] rnd;
        repeat (count) begin
            rnd = $urandom();
            set_vaddr(14'h3F00 + {9'd0, rnd[4:0]});
            vram_write(rnd[15:8]);
        end
    endtask

    task automatic check_nmi_change(input logic level, input int exp_edge);
        while (nmi_n != level) @(negedge clk);
        assert (edge_cnt == exp_edge) else begin
            value_errs++;
            $display("[ERROR] %0t nmi_n to %0b at cycle got %0d expected %0d",
                     $time, level, edge_cnt, exp_edge);
        end
    endtask

    task automatic wait_until_cycle(input int target);
        while (edge_cnt < target) @(negedge clk);
    endtask

    task automatic print_counts();
        $display("errors: %0d register, %0d pixel, %0d other, %0d pixels checked",
                 value_errs, pixel_errs, other_errs, pixel_cnt);
    endtask

    // pixel of the dot shown two edges earlier
    always @(posedge clk) begin
        int         d;
        int         r;
        int         c;
        logic       exp_valid;
        logic [5:0] exp_color;
        if (rst_n) begin
            d         = edge_cnt - 2;
            r         = 0;
            c         = 0;
            exp_valid = 1'b0;
            if (d >= 0) begin
                r         = (d / dots) % lines;
                c         = d % dots;
                exp_valid = mask_model[3] && r < vis_lines && c < vis_width;
            end
            assert (pixel_valid == exp_valid) else begin
                pixel_errs++;
                $display("[ERROR] %0t pixel_valid got %0b expected %0b",
                         $time, pixel_valid, exp_valid);
            end
            if (pixel_valid && exp_valid) begin
                pixel_cnt++;
                exp_color = ref_color(c[7:0], r[7:0], mask_model);
                assert (pixel_x == c[7:0]) else begin
                    pixel_errs++;
                    $display("[ERROR] %0t pixel_x got %0d expected %0d", $time, pixel_x, c);
                end
                assert (pixel_y == r[7:0]) else begin
                    pixel_errs++;
                    $display("[ERROR] %0t pixel_y got %0d expected %0d", $time, pixel_y, r);
                end
                assert (pixel_color == exp_color) else begin
                    pixel_errs++;
                    $display("[ERROR] %0t pixel_color at (%0d,%0d) got %02h expected %02h",
                             $time, c, r, pixel_color, exp_color);
                end
            end
            edge_cnt <= edge_cnt + 1;
        end
    end

    initial begin
        logic [7:0]  rd;
        logic [31:0] rnd;
        void'($urandom(32'h101683b1));
        ctrl_model  = 8'h00;
        mask_model  = 8'h00;
        vaddr_model = '0;
        buf_model   = 8'h00;
        buf_known   = 1'b0;
        wait (rst_n == 1'b1);
        @(negedge clk);
        assert (nmi_n == 1'b1) else begin
            value_errs++;
            $display("[ERROR] %0t nmi_n got %0b expected 1", $time, nmi_n);
        end

        // nametable column by column with the 32 step
        write_reg(ppu_pkg::reg_ctrl, 8'h84);
        for (int c = 0; c < 32; c++) begin
            set_vaddr(14'h2000 + 14'(c));
            for (int r = 0; r < 32; r++) begin
                rnd = $urandom();
                vram_write(rnd[7:0]);
            end
        end
        write_reg(ppu_pkg::reg_ctrl, 8'h80);
        set_vaddr(14'h3F00);
        for (int i = 0; i < 32; i++) begin
            rnd = $urandom();
            vram_write(rnd[7:0]);
        end

        // one extra read runs past each bank into unmapped space
        set_vaddr(14'h2000);
        repeat (1025) vram_read_check();
        set_vaddr(14'h3F00);
        repeat (33) vram_read_check();
        set_vaddr(14'h0123);
        vram_write(8'h55);
        set_vaddr(14'h0123);
        repeat (2) vram_read_check();

        check_nmi_change(1'b0, set_edge);
        check_nmi_change(1'b1, clear_edge);
        write_reg(ppu_pkg::reg_mask, 8'h0A);

        check_nmi_change(1'b0, frame_cycles + set_edge);
        // a lone high byte that the status read has to discard
        write_reg(ppu_pkg::reg_addr, 8'h3F);
        read_reg(ppu_pkg::reg_status, rd);
        assert (rd == 8'h80) else begin
            value_errs++;
            $display("[ERROR] %0t reg_rdata status got %02h expected 80", $time, rd);
        end
        assert (nmi_n == 1'b1) else begin
            value_errs++;
            $display("[ERROR] %0t nmi_n after status read got %0b expected 1", $time, nmi_n);
        end
        read_reg(ppu_pkg::reg_status, rd);
        assert (rd == 8'h00) else begin
            value_errs++;
            $display("[ERROR] %0t reg_rdata status got %02h expected 00", $time, rd);
        end
        random_palette_writes(8);
        write_reg(ppu_pkg::reg_mask, 8'h08);

        check_nmi_change(1'b0, 2 * frame_cycles + set_edge);
        random_palette_writes(8);
        write_reg(ppu_pkg::reg_mask, 8'h09);
        check_nmi_change(1'b1, 2 * frame_cycles + clear_edge);

        check_nmi_change(1'b0, 3 * frame_cycles + set_edge);
        write_reg(ppu_pkg::reg_mask, 8'h00);
        wait_until_cycle(4 * frame_cycles + 2 * dots);

        assert (pixel_cnt == 3 * vis_width * vis_lines) else begin
            other_errs++;
            $display("wrong number of pixels: saw %0d over three frames", pixel_cnt);
        end
        print_counts();
        if (value_errs + pixel_errs + other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // five frames is well past the four that the stimulus needs
    initial begin
        #(frames_run * frame_cycles * clk_period);
        $display("timeout: the run did not finish within %0d frames", frames_run);
        print_counts();
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // release on a rising edge, so the first active edge is the next one
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- rtl/ppu.sv
`timescale 1ns/1ps

module ppu (
    input  logic                        clk,
    input  logic                        rst_n,
    input  ppu_pkg::reg_sel_t           reg_sel,
    input  logic                        reg_we,
    input  logic                        reg_re,
    input  logic [7:0]                  reg_wdata,
    output logic [7:0]                  reg_rdata,
    output logic                        nmi_n,
    output logic                        pixel_valid,
    output logic [7:0]                  pixel_x,
    output logic [7:0]                  pixel_y,
    output logic [ppu_pkg::color_w-1:0] pixel_color
);

    logic [8:0]                  row;
    logic [8:0]                  col;
    ppu_pkg::vstate_t            vstate;
    logic                        vblank_set;
    logic                        vblank_clr;
    logic [7:0]                  ctrl;
    logic [7:0]                  mask;
    logic                        nt_en;
    logic                        nt_we;
    logic [ppu_pkg::nt_aw-1:0]   nt_addr;
    logic [7:0]                  nt_wdata;
    logic [7:0]                  nt_rdata;
    logic                        pal_en;
    logic                        pal_we;
    logic [ppu_pkg::pal_aw-1:0]  pal_addr;
    logic [ppu_pkg::color_w-1:0] pal_wdata;
    logic [ppu_pkg::color_w-1:0] pal_rdata;

    cpu_mem_if    cpu_mem ();
    render_mem_if render_mem ();

    frame_timing i_frame_timing (
        .clk, .rst_n, .row, .col, .vstate, .vblank_set, .vblank_clr
    );

    ppu_regs i_ppu_regs (
        .clk, .rst_n, .reg_sel, .reg_we, .reg_re, .reg_wdata, .vblank_set, .vblank_clr,
        .reg_rdata, .nmi_n, .ctrl, .mask, .mem(cpu_mem.client)
    );

    bg_renderer i_bg_renderer (
        .clk, .rst_n, .row, .col, .vstate, .ctrl, .mask, .mem(render_mem.renderer),
        .pixel_valid, .pixel_x, .pixel_y, .pixel_color
    );

    mem_arbiter i_mem_arbiter (
        .clk, .rst_n, .cpu(cpu_mem.arbiter), .rend(render_mem.arbiter),
        .nt_en, .nt_we, .nt_addr, .nt_wdata, .nt_rdata,
        .pal_en, .pal_we, .pal_addr, .pal_wdata, .pal_rdata
    );

    video_mem i_video_mem (
        .clk, .nt_en, .nt_we, .nt_addr, .nt_wdata, .nt_rdata,
        .pal_en, .pal_we, .pal_addr, .pal_wdata, .pal_rdata
    );

endmodule

//--- rtl/video_mem.sv
`timescale 1ns/1ps

module video_mem (
    input  logic                        clk,
    input  logic                        nt_en,
    input  logic                        nt_we,
    input  logic [ppu_pkg::nt_aw-1:0]   nt_addr,
    input  logic [7:0]                  nt_wdata,
    output logic [7:0]                  nt_rdata,
    input  logic                        pal_en,
    input  logic                        pal_we,
    input  logic [ppu_pkg::pal_aw-1:0]  pal_addr,
    input  logic [ppu_pkg::color_w-1:0] pal_wdata,
    output logic [ppu_pkg::color_w-1:0] pal_rdata
);

    logic [7:0]                  nt_mem [ppu_pkg::nt_size];
    logic [ppu_pkg::color_w-1:0] pal_mem [ppu_pkg::pal_size];

    // single port, read returns the old contents on a write
    always_ff @(posedge clk) begin
        if (nt_en) begin
            if (nt_we) begin
                nt_mem[nt_addr] <= nt_wdata;
            end
            nt_rdata <= nt_mem[nt_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (pal_en) begin
            if (pal_we) begin
                pal_mem[pal_addr] <= pal_wdata;
            end
            pal_rdata <= pal_mem[pal_addr];
        end
    end

endmodule

//--- rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                        clk,
    input  logic                        rst_n,
    cpu_mem_if.arbiter                  cpu,
    render_mem_if.arbiter               rend,
    output logic                        nt_en,
    output logic                        nt_we,
    output logic [ppu_pkg::nt_aw-1:0]   nt_addr,
    output logic [7:0]                  nt_wdata,
    input  logic [7:0]                  nt_rdata,
    output logic                        pal_en,
    output logic                        pal_we,
    output logic [ppu_pkg::pal_aw-1:0]  pal_addr,
    output logic [ppu_pkg::color_w-1:0] pal_wdata,
    input  logic [ppu_pkg::color_w-1:0] pal_rdata
);

    logic cpu_nt;
    logic cpu_pal;
    logic nt_gnt;
    logic pal_gnt;
    logic miss_gnt;
    logic rd_nt;
    logic rd_pal;

    // bank decode on the upper address bits
    assign cpu_nt  = cpu.addr[ppu_pkg::vaddr_w-1:ppu_pkg::nt_aw]
                  == ppu_pkg::nt_base[ppu_pkg::vaddr_w-1:ppu_pkg::nt_aw];
    assign cpu_pal = cpu.addr[ppu_pkg::vaddr_w-1:ppu_pkg::pal_aw]
                  == ppu_pkg::pal_base[ppu_pkg::vaddr_w-1:ppu_pkg::pal_aw];

    // renderer first, cpu takes a bank only when it is idle
    assign nt_gnt   = cpu.req && cpu_nt && !rend.nt_req;
    assign pal_gnt  = cpu.req && cpu_pal && !rend.pal_req;
    assign miss_gnt = cpu.req && !cpu_nt && !cpu_pal;
    assign cpu.gnt  = nt_gnt || pal_gnt || miss_gnt;

    assign nt_en    = rend.nt_req || nt_gnt;
    assign nt_we    = nt_gnt && cpu.we;
    assign nt_addr  = rend.nt_req ? rend.nt_addr : cpu.addr[ppu_pkg::nt_aw-1:0];
    assign nt_wdata = cpu.wdata;

    assign pal_en    = rend.pal_req || pal_gnt;
    assign pal_we    = pal_gnt && cpu.we;
    assign pal_addr  = rend.pal_req ? rend.pal_addr : cpu.addr[ppu_pkg::pal_aw-1:0];
    assign pal_wdata = cpu.wdata[ppu_pkg::color_w-1:0];

    // which bank the last cpu read went to
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_nt  <= 1'b0;
            rd_pal <= 1'b0;
        end else begin
            rd_nt  <= nt_gnt && !cpu.we;
            rd_pal <= pal_gnt && !cpu.we;
        end
    end

    assign rend.nt_data  = nt_rdata;
    assign rend.pal_data = pal_rdata;
    // unmapped reads return zero
    assign cpu.rdata = rd_nt ? nt_rdata : (rd_pal ? 8'(pal_rdata) : 8'h00);

endmodule

//--- rtl/bg_renderer.sv
`timescale 1ns/1ps

module bg_renderer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [8:0]                  row,
    input  logic [8:0]                  col,
    input  ppu_pkg::vstate_t            vstate,
    input  logic [7:0]                  ctrl,
    input  logic [7:0]                  mask,
    render_mem_if.renderer              mem,
    output logic                        pixel_valid,
    output logic [7:0]                  pixel_x,
    output logic [7:0]                  pixel_y,
    output logic [ppu_pkg::color_w-1:0] pixel_color
);

    logic       draw;
    logic       s1_valid;
    logic       s1_new;
    logic [7:0] s1_x;
    logic [7:0] s1_y;
    logic [3:0] held_idx;
    logic [3:0] cell_idx;
    logic       clipped;
    logic       grey_q;

    // stage 0: nametable fetch on the first dot of each cell
    assign draw = (vstate == ppu_pkg::VISIBLE)
               && (col < 9'(ppu_pkg::visible_width)) && mask[3];
    assign mem.nt_req  = draw && (col[2:0] == 3'd0);
    assign mem.nt_addr = {row[7:3], col[7:3]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid    <= 1'b0;
            pixel_valid <= 1'b0;
        end else begin
            s1_valid    <= draw;
            pixel_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_new  <= (col[2:0] == 3'd0);
        s1_x    <= col[7:0];
        s1_y    <= row[7:0];
        pixel_x <= s1_x;
        pixel_y <= s1_y;
        grey_q  <= mask[0];
        if (s1_valid && s1_new) begin
            held_idx <= mem.nt_data[3:0];
        end
    end

    // stage 1: colour index from the low nibble, then palette lookup
    assign cell_idx = s1_new ? mem.nt_data[3:0] : held_idx;
    assign clipped  = (s1_x < 8'd8) && !mask[1];

    // transparent or clipped dots show the backdrop entry
    // ctrl bit 4 picks the upper palette half
    assign mem.pal_req  = s1_valid;
    assign mem.pal_addr = (cell_idx[1:0] == 2'b00 || clipped) ? '0 : {ctrl[4], cell_idx};

    // stage 2: palette entry comes straight out of the registered read
    assign pixel_color = grey_q ? (mem.pal_data & ppu_pkg::greyscale_mask) : mem.pal_data;

endmodule

//--- rtl/ppu_regs.sv
`timescale 1ns/1ps

module ppu_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  ppu_pkg::reg_sel_t reg_sel,
    input  logic              reg_we,
    input  logic              reg_re,
    input  logic [7:0]        reg_wdata,
    input  logic              vblank_set,
    input  logic              vblank_clr,
    output logic [7:0]        reg_rdata,
    output logic              nmi_n,
    output logic [7:0]        ctrl,
    output logic [7:0]        mask,
    cpu_mem_if.client         mem
);

    logic                        vblank_flag;
    logic                        addr_latch;
    logic [ppu_pkg::vaddr_w-1:0] vaddr;
    logic [ppu_pkg::vaddr_w-1:0] vaddr_step;
    logic                        status_rd;
    logic                        data_acc;
    logic                        pend_valid;
    logic                        pend_we;
    logic [ppu_pkg::vaddr_w-1:0] pend_addr;
    logic [7:0]                  pend_wdata;
    logic                        rd_fill;
    logic [7:0]                  rd_buf;

    assign status_rd  = reg_re && (reg_sel == ppu_pkg::reg_status);
    assign data_acc   = (reg_we || reg_re) && (reg_sel == ppu_pkg::reg_data);
    // ctrl bit 2 steps down one nametable row
    assign vaddr_step = ctrl[2] ? 14'd32 : 14'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl        <= '0;
            mask        <= '0;
            vblank_flag <= 1'b0;
            addr_latch  <= 1'b0;
            vaddr       <= '0;
            pend_valid  <= 1'b0;
            rd_fill     <= 1'b0;
        end else begin
            if (reg_we && reg_sel == ppu_pkg::reg_ctrl) begin
                ctrl <= reg_wdata;
            end
            if (reg_we && reg_sel == ppu_pkg::reg_mask) begin
                mask <= reg_wdata;
            end

            if (vblank_clr) begin
                vblank_flag <= 1'b0;
            end else if (vblank_set) begin
                vblank_flag <= 1'b1;
            end else if (status_rd) begin
                vblank_flag <= 1'b0;
            end

            // high byte first, then low byte
            if (status_rd) begin
                addr_latch <= 1'b0;
            end else if (reg_we && reg_sel == ppu_pkg::reg_addr) begin
                addr_latch <= ~addr_latch;
                if (!addr_latch) begin
                    vaddr[13:8] <= reg_wdata[5:0];
                end else begin
                    vaddr[7:0] <= reg_wdata;
                end
            end

            if (data_acc) begin
                vaddr      <= vaddr + vaddr_step;
                pend_valid <= 1'b1;
            end else if (mem.gnt) begin
                pend_valid <= 1'b0;
            end

            rd_fill <= mem.gnt && !pend_we;
        end
    end

    always_ff @(posedge clk) begin
        if (data_acc) begin
            pend_we    <= reg_we;
            pend_addr  <= vaddr;
            pend_wdata <= reg_wdata;
        end
        // memory data lands the cycle after the grant
        if (rd_fill) begin
            rd_buf <= mem.rdata;
        end
        if (reg_re) begin
            case (reg_sel)
                ppu_pkg::reg_ctrl:   reg_rdata <= ctrl;
                ppu_pkg::reg_mask:   reg_rdata <= mask;
                ppu_pkg::reg_status: reg_rdata <= {vblank_flag, 7'b0};
                ppu_pkg::reg_data:   reg_rdata <= rd_fill ? mem.rdata : rd_buf;
                default:             reg_rdata <= 8'h00;
            endcase
        end
    end

    assign mem.req   = pend_valid;
    assign mem.we    = pend_we;
    assign mem.addr  = pend_addr;
    assign mem.wdata = pend_wdata;

    assign nmi_n = !(vblank_flag && ctrl[7]);

endmodule

//--- rtl/frame_timing.sv
`timescale 1ns/1ps

module frame_timing (
    input  logic             clk,
    input  logic             rst_n,
    output logic [8:0]       row,
    output logic [8:0]       col,
    output ppu_pkg::vstate_t vstate,
    output logic             vblank_set,
    output logic             vblank_clr
);

    logic             line_end;
    ppu_pkg::vstate_t vstate_next;

    assign line_end = (col == 9'(ppu_pkg::dots_per_line - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row <= '0;
            col <= '0;
        end else if (line_end) begin
            col <= '0;
            if (row == 9'(ppu_pkg::lines_per_frame - 1)) begin
                row <= '0;
            end else begin
                row <= row + 9'd1;
            end
        end else begin
            col <= col + 9'd1;
        end
    end

    // vertical state only moves on the last dot of a line
    always_comb begin
        vstate_next = vstate;
        if (line_end) begin
            case (vstate)
                ppu_pkg::VISIBLE: begin
                    if (row == 9'(ppu_pkg::visible_lines - 1)) begin
                        vstate_next = ppu_pkg::POST_LINE;
                    end
                end
                ppu_pkg::POST_LINE: begin
                    if (row == 9'(ppu_pkg::vblank_line - 1)) begin
                        vstate_next = ppu_pkg::VBLANK;
                    end
                end
                ppu_pkg::VBLANK: begin
                    if (row == 9'(ppu_pkg::prerender_line - 1)) begin
                        vstate_next = ppu_pkg::PRE_LINE;
                    end
                end
                default: begin
                    if (row == 9'(ppu_pkg::lines_per_frame - 1)) begin
                        vstate_next = ppu_pkg::VISIBLE;
                    end
                end
            endcase
        end
    end

    // row 0 is the first visible line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vstate <= ppu_pkg::VISIBLE;
        end else begin
            vstate <= vstate_next;
        end
    end

    // dot 1 of the set and clear lines
    assign vblank_set = (row == 9'(ppu_pkg::vblank_line)) && (col == 9'd1);
    assign vblank_clr = (row == 9'(ppu_pkg::prerender_line)) && (col == 9'd1);

endmodule

//--- rtl/ppu_ifs.sv
`timescale 1ns/1ps

// cpu side of video memory, one outstanding access
interface cpu_mem_if;
    logic                        req;
    logic                        we;
    logic [ppu_pkg::vaddr_w-1:0] addr;
    logic [7:0]                  wdata;
    logic [7:0]                  rdata;
    logic                        gnt;

    modport client (output req, we, addr, wdata, input rdata, gnt);
    modport arbiter (input req, we, addr, wdata, output rdata, gnt);
endinterface

// renderer side, always served in the request cycle
interface render_mem_if;
    logic                        nt_req;
    logic [ppu_pkg::nt_aw-1:0]   nt_addr;
    logic [7:0]                  nt_data;
    logic                        pal_req;
    logic [ppu_pkg::pal_aw-1:0]  pal_addr;
    logic [ppu_pkg::color_w-1:0] pal_data;

    modport renderer (output nt_req, nt_addr, pal_req, pal_addr, input nt_data, pal_data);
    modport arbiter (input nt_req, nt_addr, pal_req, pal_addr, output nt_data, pal_data);
endinterface

//--- rtl/ppu_pkg.sv
package ppu_pkg;

    // frame geometry, one dot per clk
    localparam int unsigned dots_per_line   = 341;
    localparam int unsigned lines_per_frame = 262;
    localparam int unsigned visible_width   = 256;
    localparam int unsigned visible_lines   = 240;

    // vblank flag set and clear lines
    localparam int unsigned vblank_line     = 241;
    localparam int unsigned prerender_line  = 261;

    localparam int unsigned vaddr_w = 14;

    // video address map
    localparam logic [vaddr_w-1:0] nt_base  = 14'h2000;
    localparam int unsigned        nt_size  = 1024;
    localparam int unsigned        nt_aw    = $clog2(nt_size);
    localparam logic [vaddr_w-1:0] pal_base = 14'h3F00;
    localparam int unsigned        pal_size = 32;
    localparam int unsigned        pal_aw   = $clog2(pal_size);

    localparam int unsigned color_w = 6;

    // greyscale keeps only the luma bits
    localparam logic [color_w-1:0] greyscale_mask = 6'h30;

    typedef enum logic [2:0] {
        reg_ctrl   = 3'd0,
        reg_mask   = 3'd1,
        reg_status = 3'd2,
        reg_addr   = 3'd6,
        reg_data   = 3'd7
    } reg_sel_t;

    typedef enum logic [1:0] {
        PRE_LINE,
        VISIBLE,
        POST_LINE,
        VBLANK
    } vstate_t;

endpackage
